// File: design/vldu_pkg.sv
package vldu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Geometry

  // Lanes and bytes per lane word
  localparam int unsigned NR_LANES   = 4;
  localparam int unsigned LANE_BYTES = 8;
  // One register-file word spans every lane
  localparam int unsigned WORD_BYTES = NR_LANES * LANE_BYTES;
  // Read beats are one lane word wide
  localparam int unsigned BEAT_BYTES = 8;
  localparam int unsigned VLEN       = 512;
  // Words of one vector register held by each lane
  localparam int unsigned VREG_WORDS = VLEN / 8 / WORD_BYTES;
  localparam int unsigned NR_VINSN   = 8;

  ////////////////////////////////////////////////////////////////////////////
  // Types

  typedef logic [$clog2(NR_VINSN)-1:0] vid_t;
  typedef logic [4:0]                  vreg_t;
  typedef logic [6:0]                  vl_t;
  // Element width code, log2 of bytes per element
  typedef logic [1:0]                  vsew_t;
  typedef logic [6:0]                  bytes_t;
  typedef logic [5:0]                  vaddr_t;
  typedef logic [8*BEAT_BYTES-1:0]     beat_t;
  typedef logic [8*LANE_BYTES-1:0]     lane_data_t;
  typedef logic [LANE_BYTES-1:0]       lane_strb_t;
  // Beats in the burst minus one
  typedef logic [7:0]                  burst_len_t;
  typedef logic [NR_VINSN-1:0]         insn_done_t;

  typedef struct packed {
    vid_t  id;
    vreg_t vd;
    vl_t   vl;
    vsew_t vsew;
  } insn_t;

  typedef struct packed {
    burst_len_t len;
  } burst_t;

  // One lane's share of a register-file write
  typedef struct packed {
    vid_t       id;
    vaddr_t     addr;
    lane_data_t wdata;
    lane_strb_t be;
  } lane_result_t;

  // Total bytes moved by a load
  function automatic bytes_t insn_bytes(insn_t insn);
    return bytes_t'(insn.vl) << insn.vsew;
  endfunction

endpackage

// File: design/vldu_insn_queue.sv
module vldu_insn_queue #(
  parameter int unsigned InsnQueueDepth = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Sequencer requests
  input  vldu_pkg::insn_t      pe_req_i,
  input  logic                 pe_req_valid_i,
  output logic                 pe_req_ready_o,
  // Towards the beat unpacker
  output vldu_pkg::insn_t      issue_insn_o,
  output logic                 issue_valid_o,
  input  logic                 issue_done_i,
  // From the result queue
  input  logic                 word_pop_i,
  // Completion
  output vldu_pkg::insn_done_t pe_resp_o,
  output logic                 load_complete_o
);
  import vldu_pkg::*;

  localparam int unsigned IdxW = (InsnQueueDepth > 1) ? $clog2(InsnQueueDepth) : 1;
  localparam int unsigned CntW = $clog2(InsnQueueDepth + 1);

  ////////////////////////////////////////////////////////////////////////////
  // Instruction storage

  insn_t [InsnQueueDepth-1:0] queue_q;

  // One pointer per phase
  logic [IdxW-1:0] accept_pnt_q, accept_pnt_d;
  logic [IdxW-1:0] issue_pnt_q, issue_pnt_d;
  logic [IdxW-1:0] commit_pnt_q, commit_pnt_d;
  // Instructions still waiting to issue or commit
  logic [CntW-1:0] issue_cnt_q, issue_cnt_d;
  logic [CntW-1:0] commit_cnt_q, commit_cnt_d;

  // Ids in flight
  logic [NR_VINSN-1:0] running_q, running_d;
  // Bytes of the head instruction not yet written back
  bytes_t              commit_bytes_q, commit_bytes_d;
  insn_done_t          pe_resp_d;

  logic  accept;
  logic  commit_valid;
  insn_t commit_insn;

  // Full once every slot waits for commit
  assign pe_req_ready_o = (commit_cnt_q != CntW'(InsnQueueDepth));
  assign accept         = pe_req_valid_i && pe_req_ready_o && !running_q[pe_req_i.id];

  assign issue_insn_o  = queue_q[issue_pnt_q];
  assign issue_valid_o = (issue_cnt_q != '0);

  assign commit_insn  = queue_q[commit_pnt_q];
  assign commit_valid = (commit_cnt_q != '0);

  ////////////////////////////////////////////////////////////////////////////
  // Pointer and count update

  always_comb begin
    accept_pnt_d    = accept_pnt_q;
    issue_pnt_d     = issue_pnt_q;
    commit_pnt_d    = commit_pnt_q;
    issue_cnt_d     = issue_cnt_q;
    commit_cnt_d    = commit_cnt_q;
    running_d       = running_q;
    commit_bytes_d  = commit_bytes_q;
    pe_resp_d       = '0;
    load_complete_o = 1'b0;

    // Unpacker finished the issue head
    if (issue_done_i) begin
      issue_pnt_d = (issue_pnt_q == IdxW'(InsnQueueDepth - 1)) ? '0 : issue_pnt_q + 1'b1;
      issue_cnt_d = issue_cnt_d - 1'b1;
    end

    // One word retired, floor at zero on a partial last word
    if (word_pop_i) begin
      commit_bytes_d = (commit_bytes_q > bytes_t'(WORD_BYTES)) ?
                       commit_bytes_q - bytes_t'(WORD_BYTES) : '0;
    end

    // Head instruction fully written
    if (commit_valid && (commit_bytes_d == '0)) begin
      pe_resp_d[commit_insn.id] = 1'b1;
      load_complete_o           = 1'b1;
      // Frees the id for a later request
      running_d[commit_insn.id] = 1'b0;
      commit_cnt_d = commit_cnt_d - 1'b1;
      commit_pnt_d = (commit_pnt_q == IdxW'(InsnQueueDepth - 1)) ? '0 : commit_pnt_q + 1'b1;
      // Next head, if any, provides the new byte count
      if (commit_cnt_d != '0) begin
        commit_bytes_d = insn_bytes(queue_q[commit_pnt_d]);
      end
    end

    // New instruction
    if (accept) begin
      running_d[pe_req_i.id] = 1'b1;
      // Becomes the commit head straight away when nothing else waits
      if (commit_cnt_d == '0) begin
        commit_bytes_d = insn_bytes(pe_req_i);
      end
      accept_pnt_d = (accept_pnt_q == IdxW'(InsnQueueDepth - 1)) ? '0 : accept_pnt_q + 1'b1;
      issue_cnt_d  = issue_cnt_d + 1'b1;
      commit_cnt_d = commit_cnt_d + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Registers

  always_ff @(posedge clk_i) begin
    if (accept) begin
      queue_q[accept_pnt_q] <= pe_req_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q   <= '0;
      issue_pnt_q    <= '0;
      commit_pnt_q   <= '0;
      issue_cnt_q    <= '0;
      commit_cnt_q   <= '0;
      running_q      <= '0;
      commit_bytes_q <= '0;
      pe_resp_o      <= '0;
    end else begin
      accept_pnt_q   <= accept_pnt_d;
      issue_pnt_q    <= issue_pnt_d;
      commit_pnt_q   <= commit_pnt_d;
      issue_cnt_q    <= issue_cnt_d;
      commit_cnt_q   <= commit_cnt_d;
      running_q      <= running_d;
      commit_bytes_q <= commit_bytes_d;
      // Done bit trails the commit by one cycle
      pe_resp_o      <= pe_resp_d;
    end
  end

endmodule

// File: design/vldu_beat_unpacker.sv
module vldu_beat_unpacker (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  // Issue head from the instruction queue
  input  vldu_pkg::insn_t                                 issue_insn_i,
  input  logic                                            issue_valid_i,
  output logic                                            issue_done_o,
  // Address generator
  input  vldu_pkg::burst_t                                burst_i,
  input  logic                                            burst_valid_i,
  output logic                                            burst_ready_o,
  // Read data
  input  vldu_pkg::beat_t                                 r_data_i,
  input  logic                                            r_valid_i,
  output logic                                            r_ready_o,
  // Result queue
  input  logic                                            queue_full_i,
  output logic                                            word_push_o,
  output vldu_pkg::lane_result_t [vldu_pkg::NR_LANES-1:0] push_result_o
);
  import vldu_pkg::*;

  // Each full beat lands in exactly one lane
  localparam int unsigned LaneLsb = $clog2(LANE_BYTES);
  localparam int unsigned LaneW   = $clog2(NR_LANES);

  ////////////////////////////////////////////////////////////////////////////
  // Packing state

  // Set while the counters wait for the next issue head
  logic       fresh_q;
  // Bytes left from the start of the current word
  bytes_t     rem_q, rem_eff;
  // Next free byte in the current word
  bytes_t     pnt_q, pnt_eff, pnt_next;
  // Word offset within the destination register
  vaddr_t     off_q, off_eff;
  burst_len_t beat_cnt_q;
  // Lane data gathered so far
  lane_data_t [NR_LANES-1:0] word_q;

  logic             fire;
  logic             insn_end;
  logic             word_full;
  logic [LaneW-1:0] lane_sel;

  always_comb begin
    // A fresh head starts at byte zero of word zero
    rem_eff  = fresh_q ? insn_bytes(issue_insn_i) : rem_q;
    pnt_eff  = fresh_q ? '0 : pnt_q;
    off_eff  = fresh_q ? '0 : off_q;
    pnt_next = pnt_eff + bytes_t'(BEAT_BYTES);
    lane_sel = pnt_eff[LaneLsb +: LaneW];

    // Beat needs data, its burst, an instruction and room downstream
    fire      = r_valid_i && burst_valid_i && issue_valid_i && !queue_full_i;
    insn_end  = (pnt_next >= rem_eff);
    word_full = (pnt_next == bytes_t'(WORD_BYTES));

    r_ready_o     = fire;
    burst_ready_o = fire && (beat_cnt_q == burst_i.len);
    word_push_o   = fire && (insn_end || word_full);
    issue_done_o  = fire && insn_end;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Word assembly

  always_comb begin
    for (int l = 0; l < NR_LANES; l++) begin
      push_result_o[l].id    = issue_insn_i.id;
      push_result_o[l].addr  = vaddr_t'(issue_insn_i.vd * VREG_WORDS) + off_eff;
      // Current beat bypasses the buffer
      push_result_o[l].wdata = (fire && (lane_sel == LaneW'(l))) ? r_data_i : word_q[l];
      // Only bytes inside the instruction get written
      for (int b = 0; b < LANE_BYTES; b++) begin
        push_result_o[l].be[b] = (bytes_t'(l * LANE_BYTES + b) < rem_eff);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (fire) begin
      word_q[lane_sel] <= r_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fresh_q    <= 1'b1;
      rem_q      <= '0;
      pnt_q      <= '0;
      off_q      <= '0;
      beat_cnt_q <= '0;
    end else if (fire) begin
      // Last beat of the instruction rearms the load
      fresh_q <= insn_end;
      if (word_push_o) begin
        pnt_q <= '0;
        rem_q <= rem_eff - bytes_t'(WORD_BYTES);
        off_q <= off_eff + 1'b1;
      end else begin
        pnt_q <= pnt_next;
        rem_q <= rem_eff;
        off_q <= off_eff;
      end
      // Beat count restarts with every burst
      beat_cnt_q <= burst_ready_o ? '0 : beat_cnt_q + 1'b1;
    end
  end

endmodule

// File: design/vldu_result_queue.sv
module vldu_result_queue #(
  parameter int unsigned ResultQueueDepth = 2
) (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  // From the beat unpacker
  input  logic                                            word_push_i,
  input  vldu_pkg::lane_result_t [vldu_pkg::NR_LANES-1:0] push_result_i,
  output logic                                            queue_full_o,
  // Lane write ports
  output logic                   [vldu_pkg::NR_LANES-1:0] lane_req_o,
  output vldu_pkg::lane_result_t [vldu_pkg::NR_LANES-1:0] lane_result_o,
  input  logic                   [vldu_pkg::NR_LANES-1:0] lane_gnt_i,
  // Entry retired
  output logic                                            word_pop_o
);
  import vldu_pkg::*;

  localparam int unsigned IdxW = (ResultQueueDepth > 1) ? $clog2(ResultQueueDepth) : 1;
  localparam int unsigned CntW = $clog2(ResultQueueDepth + 1);

  ////////////////////////////////////////////////////////////////////////////
  // Storage

  lane_result_t [ResultQueueDepth-1:0][NR_LANES-1:0] data_q;
  // Lanes still to grant, per entry
  logic [ResultQueueDepth-1:0][NR_LANES-1:0] valid_q, valid_d;

  logic [IdxW-1:0] wr_pnt_q, wr_pnt_d;
  logic [IdxW-1:0] rd_pnt_q, rd_pnt_d;
  logic [CntW-1:0] cnt_q, cnt_d;

  assign queue_full_o  = (cnt_q == CntW'(ResultQueueDepth));
  // Head entry faces the lanes
  assign lane_req_o    = valid_q[rd_pnt_q];
  assign lane_result_o = data_q[rd_pnt_q];

  always_comb begin
    valid_d    = valid_q;
    wr_pnt_d   = wr_pnt_q;
    rd_pnt_d   = rd_pnt_q;
    cnt_d      = cnt_q;
    word_pop_o = 1'b0;

    // Each grant drops that lane's request
    for (int l = 0; l < NR_LANES; l++) begin
      if (lane_req_o[l] && lane_gnt_i[l]) begin
        valid_d[rd_pnt_q][l] = 1'b0;
      end
    end

    // Retire in the same cycle as the last grant
    if ((cnt_q != '0) && (valid_d[rd_pnt_q] == '0)) begin
      word_pop_o = 1'b1;
      rd_pnt_d   = (rd_pnt_q == IdxW'(ResultQueueDepth - 1)) ? '0 : rd_pnt_q + 1'b1;
      cnt_d      = cnt_d - 1'b1;
    end

    // New word requests on every lane
    if (word_push_i) begin
      valid_d[wr_pnt_q] = '1;
      wr_pnt_d = (wr_pnt_q == IdxW'(ResultQueueDepth - 1)) ? '0 : wr_pnt_q + 1'b1;
      cnt_d    = cnt_d + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (word_push_i) begin
      data_q[wr_pnt_q] <= push_result_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      valid_q  <= valid_d;
      wr_pnt_q <= wr_pnt_d;
      rd_pnt_q <= rd_pnt_d;
      cnt_q    <= cnt_d;
    end
  end

endmodule

// File: design/vldu_top.sv
module vldu_top #(
  parameter int unsigned InsnQueueDepth   = 4,
  parameter int unsigned ResultQueueDepth = 2
) (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  // Sequencer
  input  vldu_pkg::insn_t                                 pe_req_i,
  input  logic                                            pe_req_valid_i,
  output logic                                            pe_req_ready_o,
  output vldu_pkg::insn_done_t                            pe_resp_o,
  output logic                                            load_complete_o,
  // Address generator
  input  vldu_pkg::burst_t                                burst_i,
  input  logic                                            burst_valid_i,
  output logic                                            burst_ready_o,
  // Read data
  input  vldu_pkg::beat_t                                 r_data_i,
  input  logic                                            r_valid_i,
  output logic                                            r_ready_o,
  // Lanes
  output logic                   [vldu_pkg::NR_LANES-1:0] lane_req_o,
  output vldu_pkg::lane_result_t [vldu_pkg::NR_LANES-1:0] lane_result_o,
  input  logic                   [vldu_pkg::NR_LANES-1:0] lane_gnt_i
);
  import vldu_pkg::*;

  // Issue handshake
  insn_t issue_insn;
  logic  issue_valid;
  logic  issue_done;

  // Word path between unpacker and result queue
  logic                         word_push;
  lane_result_t [NR_LANES-1:0]  push_result;
  logic                         queue_full;
  logic                         word_pop;

  vldu_insn_queue #(
    .InsnQueueDepth (InsnQueueDepth)
  ) i_insn_queue (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .pe_req_i        (pe_req_i),
    .pe_req_valid_i  (pe_req_valid_i),
    .pe_req_ready_o  (pe_req_ready_o),
    .issue_insn_o    (issue_insn),
    .issue_valid_o   (issue_valid),
    .issue_done_i    (issue_done),
    .word_pop_i      (word_pop),
    .pe_resp_o       (pe_resp_o),
    .load_complete_o (load_complete_o)
  );

  vldu_beat_unpacker i_beat_unpacker (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .issue_insn_i  (issue_insn),
    .issue_valid_i (issue_valid),
    .issue_done_o  (issue_done),
    .burst_i       (burst_i),
    .burst_valid_i (burst_valid_i),
    .burst_ready_o (burst_ready_o),
    .r_data_i      (r_data_i),
    .r_valid_i     (r_valid_i),
    .r_ready_o     (r_ready_o),
    .queue_full_i  (queue_full),
    .word_push_o   (word_push),
    .push_result_o (push_result)
  );

  vldu_result_queue #(
    .ResultQueueDepth (ResultQueueDepth)
  ) i_result_queue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .word_push_i   (word_push),
    .push_result_i (push_result),
    .queue_full_o  (queue_full),
    .lane_req_o    (lane_req_o),
    .lane_result_o (lane_result_o),
    .lane_gnt_i    (lane_gnt_i),
    .word_pop_o    (word_pop)
  );

endmodule

// File: test/tb_vldu.sv
module tb_vldu;
  timeunit 1ns;
  timeprecision 100ps;
  import vldu_pkg::*;

  localparam int NrInsn     = 40;
  localparam int QueueDepth = 4;
  // Allowance of 64 cycles per load
  localparam int MaxCycles  = NrInsn * 64;

  typedef logic [NR_LANES-1:0] lanes_t;

  logic                        clk_i;
  logic                        rst_ni;
  insn_t                       pe_req_i;
  logic                        pe_req_valid_i;
  logic                        pe_req_ready_o;
  insn_done_t                  pe_resp_o;
  logic                        load_complete_o;
  burst_t                      burst_i;
  logic                        burst_valid_i;
  logic                        burst_ready_o;
  beat_t                       r_data_i;
  logic                        r_valid_i;
  logic                        r_ready_o;
  lanes_t                      lane_req_o;
  lane_result_t [NR_LANES-1:0] lane_result_o;
  lanes_t                      lane_gnt_i;

  // Memory stream and expected lane writes
  insn_t        insns [NrInsn];
  beat_t        beat_q [$];
  int           burst_q [$];
  lane_result_t exp_lane [NR_LANES][$];
  // Accepted ids in order, waiting for completion
  vid_t         done_q [$];
  vid_t         done_id;
  logic [NR_VINSN-1:0] running = '0;
  insn_done_t   resp_exp = '0;
  int           pending = 0;
  int           accept_cnt = 0;
  int           done_cnt = 0;
  int           cycle_cnt = 0;

  vldu_top #(
    .InsnQueueDepth   (QueueDepth),
    .ResultQueueDepth (2)
  ) i_vldu_top (
    .clk_i, .rst_ni, .pe_req_i, .pe_req_valid_i, .pe_req_ready_o, .pe_resp_o,
    .load_complete_o, .burst_i, .burst_valid_i, .burst_ready_o, .r_data_i,
    .r_valid_i, .r_ready_o, .lane_req_o, .lane_result_o, .lane_gnt_i
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic check_value(input string what, input logic [127:0] got,
                             input logic [127:0] want);
    if (got !== want) begin
      $display("** Error at %0d ns: %s is %0h, expected %0h", $time, what, got, want);
      $display("Test failed");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  // Inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus and expected words

  task automatic build_stimulus();
    int           nbytes;
    int           nbeats;
    int           left;
    int           len;
    beat_t        insn_beats [8];
    lane_result_t want;
    for (int i = 0; i < NrInsn; i++) begin
      // Rotating ids, now and then repeating the previous one so it may still run
      if ((i != 0) && ($urandom_range(0, 7) == 0)) begin
        insns[i].id = insns[i-1].id;
      end else begin
        insns[i].id = vid_t'(i % NR_VINSN);
      end
      insns[i].vd   = vreg_t'($urandom_range(0, 31));
      insns[i].vsew = vsew_t'($urandom_range(0, 3));
      insns[i].vl   = vl_t'($urandom_range(1, 64 >> insns[i].vsew));
      nbytes = int'(insns[i].vl) << insns[i].vsew;
      nbeats = (nbytes + BEAT_BYTES - 1) / BEAT_BYTES;
      for (int b = 0; b < nbeats; b++) begin
        insn_beats[b] = {$urandom, $urandom};
        beat_q.push_back(insn_beats[b]);
      end
      // Random split into bursts, none crossing into the next load
      left = nbeats;
      while (left != 0) begin
        len = $urandom_range(1, left);
        burst_q.push_back(len - 1);
        left -= len;
      end
      // Word k, lane l holds stream bytes 32k+8l up to 32k+8l+7
      for (int k = 0; k < (nbytes + WORD_BYTES - 1) / WORD_BYTES; k++) begin
        for (int l = 0; l < NR_LANES; l++) begin
          want.id    = insns[i].id;
          want.addr  = vaddr_t'(int'(insns[i].vd) * 2 + k);
          want.wdata = (4 * k + l < nbeats) ? insn_beats[4 * k + l] : '0;
          for (int b = 0; b < LANE_BYTES; b++) begin
            want.be[b] = (WORD_BYTES * k + LANE_BYTES * l + b < nbytes);
          end
          exp_lane[l].push_back(want);
        end
      end
    end
  endtask

  task automatic drive_requests();
    for (int i = 0; i < NrInsn; i++) begin
      pe_req_i       = insns[i];
      pe_req_valid_i = 1'b1;
      // Held until the monitor sees the handshake
      wait (accept_cnt == i + 1);
      next_cycle();
      pe_req_valid_i = 1'b0;
      repeat ($urandom_range(0, 2)) next_cycle();
    end
  endtask

  task automatic send_beat(input beat_t data, input logic last);
    int gap;
    gap = $urandom_range(0, 2);
    if (gap != 0) begin
      r_valid_i = 1'b0;
      repeat (gap) next_cycle();
    end
    r_data_i  = data;
    r_valid_i = 1'b1;
    @(negedge clk_i);
    while (!r_ready_o) @(negedge clk_i);
    // Burst handshake only on its final beat
    check_value("burst_ready_o on beat", 128'(burst_ready_o), 128'(last));
    next_cycle();
  endtask

  task automatic drive_reads();
    int len;
    burst_valid_i = 1'b1;
    while (burst_q.size() != 0) begin
      len         = burst_q.pop_front();
      burst_i.len = burst_len_t'(len);
      for (int b = 0; b <= len; b++) begin
        send_beat(beat_q.pop_front(), b == len);
      end
    end
    burst_valid_i = 1'b0;
    r_valid_i     = 1'b0;
  endtask

  // Lanes grant at random
  initial begin
    wait (rst_ni);
    forever begin
      next_cycle();
      lane_gnt_i = lanes_t'($urandom);
    end
  end

  task automatic check_word(input int lane);
    lane_result_t want;
    lane_result_t got;
    logic [63:0]  mask;
    check_value($sformatf("word expected on lane %0d", lane),
                128'(exp_lane[lane].size() != 0), 128'(1));
    want = exp_lane[lane].pop_front();
    got  = lane_result_o[lane];
    // Only enabled bytes carry data
    for (int b = 0; b < LANE_BYTES; b++) begin
      mask[8*b +: 8] = {8{want.be[b]}};
    end
    check_value($sformatf("lane %0d id", lane), 128'(got.id), 128'(want.id));
    check_value($sformatf("lane %0d addr", lane), 128'(got.addr), 128'(want.addr));
    check_value($sformatf("lane %0d be", lane), 128'(got.be), 128'(want.be));
    check_value($sformatf("lane %0d wdata", lane), 128'(got.wdata & mask),
                128'(want.wdata & mask));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Monitor, sampled mid-cycle

  always @(negedge clk_i) begin
    if (rst_ni) begin
      cycle_cnt++;
      if (cycle_cnt > MaxCycles) begin
        $display("Timeout after %0d cycles, %0d of %0d loads done", MaxCycles, done_cnt, NrInsn);
        $display("Test failed");
        $fatal(1, "Simulation stopped by timeout");
      end else begin
        check_value("pe_req_ready_o", 128'(pe_req_ready_o), 128'(pending != QueueDepth));
        // Done bit trails load_complete_o by one cycle
        check_value("pe_resp_o", 128'(pe_resp_o), 128'(resp_exp));
        check_value("burst_ready_o without beat", 128'(burst_ready_o && !r_ready_o), 128'(0));
        resp_exp = '0;
        // An id still running is held off, even in the cycle of its own commit
        if (pe_req_valid_i && pe_req_ready_o && !running[pe_req_i.id]) begin
          running[pe_req_i.id] = 1'b1;
          done_q.push_back(pe_req_i.id);
          pending++;
          accept_cnt++;
        end
        if (load_complete_o) begin
          check_value("load pending at completion", 128'(done_q.size() != 0), 128'(1));
          done_id           = done_q.pop_front();
          resp_exp[done_id] = 1'b1;
          running[done_id]  = 1'b0;
          pending--;
          done_cnt++;
        end
        for (int l = 0; l < NR_LANES; l++) begin
          if (lane_req_o[l] && lane_gnt_i[l]) begin
            check_word(l);
          end
        end
      end
    end
  end

  initial begin
    rst_ni         = 1'b0;
    pe_req_i       = '0;
    pe_req_valid_i = 1'b0;
    burst_i        = '0;
    burst_valid_i  = 1'b0;
    r_data_i       = '0;
    r_valid_i      = 1'b0;
    lane_gnt_i     = '0;
    void'($urandom(32'h01490717));
    build_stimulus();
    repeat (8) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    fork
      drive_requests();
      drive_reads();
    join
    wait (done_cnt == NrInsn);
    // Let the last done pulse reach the monitor
    repeat (2) @(negedge clk_i);
    for (int l = 0; l < NR_LANES; l++) begin
      check_value($sformatf("words left on lane %0d", l), 128'(exp_lane[l].size()), 128'(0));
    end
    $display("Test passed");
    $finish;
  end

endmodule

// File: sources.f
design/vldu_pkg.sv
design/vldu_insn_queue.sv
design/vldu_beat_unpacker.sv
design/vldu_result_queue.sv
design/vldu_top.sv
test/tb_vldu.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_vldu
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
PASS_MSG  ?= Test passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
